//--- files.f
+incdir+common
+incdir+test
common/paintPkg.sv
logic/rasterTiming.sv
pixelStore/pixelStore.sv
logic/brushRegs.sv
logic/videoOutput.sv
logic/paintTop.sv
test/paintTb.sv

//--- run.sh
#!/bin/sh
# build the paint testbench with Verilator and run it
# a nonzero exit means the build or the simulation failed

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module paintTb -f files.f -o paintTb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

# any failing check ends in a fatal, so the exit status decides
./obj_dir/paintTb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0

//--- test/apbHost.svh
`ifndef APB_HOST_SVH
`define APB_HOST_SVH

// apb host side, inputs driven on the rising edge

// one transfer, setup cycle then access until pready
task automatic apbTransfer(
  input  logic        isWrite,
  input  logic [7:0]  addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        err
);
  int waitCount;
  @(posedge clk);
  psel <= 1'b1;
  penable <= 1'b0;
  pwrite <= isWrite;
  paddr <= addr;
  pwdata <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  waitCount = 0;
  // pready seen at the edge closing each access cycle
  do begin
    @(posedge clk);
    waitCount++;
  end while (!pready && waitCount < APB_TIMEOUT);
  assert (pready) else stopOnError("apb access got no pready before the timeout");
  accessCycles = waitCount;
  rdata = prdata;
  err = pslverr;
  // back to idle after the accepting edge
  psel <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  logic err;
  apbTransfer(1'b1, addr, data, unused, err);
endtask

task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
  apbTransfer(1'b0, addr, 32'h0, data, err);
endtask

`endif

//--- test/paintTb.sv
`include "paint_cfg.svh"

module paintTb;

  localparam int CANVAS_DIM = 1 << `CANVAS_BITS;
  localparam int CANVAS_WORDS = CANVAS_DIM * CANVAS_DIM;
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
  localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;
  localparam int APB_TIMEOUT = 20000;
  localparam int IDLE_POLLS = 10000;
  localparam int RUN_LIMIT = 4000000;
  localparam int PAINT_COUNT = 40;
  // palette by color code
  localparam paintPkg::rgb_t PALETTE [8] = '{
    12'h000, 12'hF00, 12'h0F0, 12'h00F, 12'hFF0, 12'hF0F, 12'h0FF, 12'hFFF
  };

  logic clk = 1'b0;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  paintPkg::videoOut_t video;

  // shadow of the canvas, as written by this bench
  paintPkg::colorCode_t shadow [CANVAS_WORDS];
  string testName;
  logic rgbCheck = 1'b0;
  int accessCycles;
  integer seed;
  // compare side, position now on the output
  int warmup = 0;
  int hPos = 0;
  int vPos = 0;

  paintTop paintTop_inst (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .video(video)
  );

  always #5 clk = ~clk;

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "apbHost.svh"

  // blank, then border, then canvas contents
  function automatic paintPkg::rgb_t expectedRgb(input int x, input int y);
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
      return 12'h000;
    end
    if (x >= CANVAS_DIM || y >= CANVAS_DIM) begin
      return PALETTE[`BORDER_COLOR];
    end
    return PALETTE[shadow[y * CANVAS_DIM + x]];
  endfunction

  // output runs 3 cycles behind the raster counters
  always @(negedge clk) begin
    logic live;
    logic hsyncExp;
    logic vsyncExp;
    paintPkg::rgb_t rgbExp;
    live = !reset && warmup >= 3;
    hsyncExp = !live || !(hPos >= H_SYNC_START && hPos < H_SYNC_END);
    vsyncExp = !live || !(vPos >= V_SYNC_START && vPos < V_SYNC_END);
    rgbExp = live ? expectedRgb(hPos, vPos) : 12'h000;
    assert (video.hsync == hsyncExp) else stopOnError($sformatf(
      "[ERROR] %s: hsync at (%0d,%0d) expected %0b actual %0b",
      testName, hPos, vPos, hsyncExp, video.hsync));
    assert (video.vsync == vsyncExp) else stopOnError($sformatf(
      "[ERROR] %s: vsync at (%0d,%0d) expected %0b actual %0b",
      testName, hPos, vPos, vsyncExp, video.vsync));
    // canvas area only once the shadow is known
    if (!live || rgbCheck || hPos >= CANVAS_DIM || vPos >= CANVAS_DIM) begin
      assert (video.rgb == rgbExp) else stopOnError($sformatf(
        "[ERROR] %s: rgb at (%0d,%0d) expected %h actual %h",
        testName, hPos, vPos, rgbExp, video.rgb));
    end
    if (reset) begin
      warmup = 0;
      hPos = 0;
      vPos = 0;
    end else if (warmup < 3) begin
      warmup++;
    end else if (hPos == `H_TOTAL - 1) begin
      hPos = 0;
      vPos = (vPos == `V_TOTAL - 1) ? 0 : vPos + 1;
    end else begin
      hPos++;
    end
  end

  task automatic checkReg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    logic err;
    apbRead(addr, data, err);
    assert (data == expected) else stopOnError($sformatf(
      "[ERROR] %s: offset %h expected %h actual %h", testName, addr, expected, data));
    assert (!err) else stopOnError($sformatf(
      "[ERROR] %s: pslverr at offset %h expected 0 actual 1", testName, addr));
  endtask

  // poll busy until it drops
  task automatic waitIdle();
    logic [31:0] status;
    logic err;
    int polls;
    polls = 0;
    status = 32'h1;
    while (status[0] && polls < IDLE_POLLS) begin
      apbRead(`REG_STATUS, status, err);
      polls++;
    end
    assert (!status[0]) else stopOnError("busy did not drop after the clear");
  endtask

  task automatic clearShadow();
    for (int i = 0; i < CANVAS_WORDS; i++) begin
      shadow[i] = paintPkg::ERASE;
    end
  endtask

  // stamps only inside the canvas
  task automatic paintPixel(input int x, input int y, input int c);
    apbWrite(`REG_X, x);
    apbWrite(`REG_Y, y);
    apbWrite(`REG_COLOR, c);
    apbWrite(`REG_CMD, 32'd1);
    if (x < CANVAS_DIM && y < CANVAS_DIM) begin
      shadow[y * CANVAS_DIM + x] = 3'(c);
    end
  endtask

  // let the last write land, then one whole frame
  task automatic checkFrame();
    repeat (4) @(posedge clk);
    rgbCheck = 1'b1;
    repeat (FRAME_CYCLES) @(posedge clk);
    rgbCheck = 1'b0;
  endtask

  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    stopOnError("run went past its cycle limit");
  end

  initial begin
    int x;
    int y;
    int c;
    logic [31:0] data;
    logic err;
    seed = 32'h16e0;
    testName = "reset";
    reset <= 1'b1;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= '0;
    pwdata <= '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // syncs and blanking over a frame
    repeat (FRAME_CYCLES) @(posedge clk);

    testName = "clear";
    apbWrite(`REG_CMD, 32'd2);
    checkReg(`REG_STATUS, 32'd1);
    waitIdle();
    clearShadow();
    checkFrame();

    testName = "paint";
    for (int i = 0; i < PAINT_COUNT; i++) begin
      x = $unsigned($random(seed)) % CANVAS_DIM;
      y = $unsigned($random(seed)) % CANVAS_DIM;
      c = $unsigned($random(seed)) % 8;
      paintPixel(x, y, c);
    end
    checkFrame();

    testName = "outside";
    for (int i = 0; i < 8; i++) begin
      x = CANVAS_DIM + $unsigned($random(seed)) % CANVAS_DIM;
      y = $unsigned($random(seed)) % CANVAS_DIM;
      c = 1 + $unsigned($random(seed)) % 7;
      // odd passes put y off the canvas instead
      if (i % 2 == 1) begin
        paintPixel(y, x, c);
      end else begin
        paintPixel(x, y, c);
      end
    end
    paintPixel(200, 200, paintPkg::WHITE);
    checkFrame();

    testName = "registers";
    apbWrite(`REG_X, 32'h5A);
    apbWrite(`REG_Y, 32'hA7);
    apbWrite(`REG_COLOR, 32'hFD);
    checkReg(`REG_X, 32'h5A);
    checkReg(`REG_Y, 32'hA7);
    checkReg(`REG_COLOR, 32'h5);
    checkReg(`REG_CMD, 32'h0);
    apbRead(8'h20, data, err);
    assert (err) else stopOnError($sformatf(
      "[ERROR] %s: pslverr at offset 20 expected 1 actual %0b", testName, err));

    testName = "backpressure";
    apbWrite(`REG_X, 32'd3);
    apbWrite(`REG_Y, 32'd9);
    apbWrite(`REG_COLOR, paintPkg::GREEN);
    apbWrite(`REG_CMD, 32'd2);
    // paint held behind the running clear
    apbWrite(`REG_CMD, 32'd1);
    assert (accessCycles > 16000) else stopOnError($sformatf(
      "[ERROR] %s: held cycles expected > 16000 actual %0d", testName, accessCycles));
    checkReg(`REG_STATUS, 32'd0);
    clearShadow();
    shadow[9 * CANVAS_DIM + 3] = paintPkg::GREEN;
    checkFrame();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- logic/paintTop.sv
module paintTop (
  input  logic clk,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [7:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output paintPkg::videoOut_t video
);

  paintPkg::rasterInfo_t raster;
  paintPkg::storeWrite_t write;
  paintPkg::pixelInfo_t pixel;

  // scan position, one cycle behind the counters
  rasterTiming rasterTiming_inst (
    .clk(clk),
    .reset(reset),
    .raster(raster)
  );

  // host side feeds the store write port
  brushRegs brushRegs_inst (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .write(write)
  );

  pixelStore pixelStore_inst (
    .clk(clk),
    .reset(reset),
    .raster(raster),
    .write(write),
    .pixel(pixel)
  );

  videoOutput videoOutput_inst (
    .clk(clk),
    .reset(reset),
    .pixel(pixel),
    .video(video)
  );

endmodule

//--- logic/videoOutput.sv
`include "paint_cfg.svh"

module videoOutput (
  input  logic clk,
  input  logic reset,
  input  paintPkg::pixelInfo_t pixel,
  output paintPkg::videoOut_t video
);

  paintPkg::rgb_t paletteRgb;
  paintPkg::rgb_t rgbNext;

  // palette
  always_comb begin
    case (pixel.color)
      paintPkg::ERASE: paletteRgb = 12'h000;
      paintPkg::RED: paletteRgb = 12'hF00;
      paintPkg::GREEN: paletteRgb = 12'h0F0;
      paintPkg::BLUE: paletteRgb = 12'h00F;
      paintPkg::YELLOW: paletteRgb = 12'hFF0;
      paintPkg::PURPLE: paletteRgb = 12'hF0F;
      paintPkg::CYAN: paletteRgb = 12'h0FF;
      paintPkg::WHITE: paletteRgb = 12'hFFF;
      default: paletteRgb = 12'h000;
    endcase
  end

  // black in blanking
  assign rgbNext = pixel.active ? paletteRgb : 12'h000;

  always_ff @(posedge clk) begin
    if (reset) begin
      video.rgb <= '0;
      video.hsync <= 1'b1;
      video.vsync <= 1'b1;
    end else begin
      video.rgb <= rgbNext;
      video.hsync <= pixel.hsync;
      video.vsync <= pixel.vsync;
    end
  end

endmodule

//--- logic/brushRegs.sv
`include "paint_cfg.svh"

module brushRegs (
  input  logic clk,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [7:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output paintPkg::storeWrite_t write
);

  localparam int CANVAS_DIM = 1 << `CANVAS_BITS;
  localparam logic [31:0] CMD_PAINT = 32'd1;
  localparam logic [31:0] CMD_CLEAR = 32'd2;

  logic [7:0] regX;
  logic [7:0] regY;
  paintPkg::colorCode_t regColor;
  paintPkg::fsmState_t state;
  paintPkg::canvasAddr_t clearAddr;
  logic busy;
  logic access;
  logic cmdWrite;
  logic cmdHeld;
  logic mapped;
  logic inCanvas;
  logic paintGo;
  logic clearGo;
  logic writeEn;
  paintPkg::canvasAddr_t writeAddr;
  paintPkg::colorCode_t writeColor;

  assign busy = state == paintPkg::CLEARING;
  assign access = psel && penable;
  assign cmdWrite = access && pwrite && (paddr == `REG_CMD);
  // a command during a clear waits here
  assign cmdHeld = cmdWrite && busy;
  assign pready = access && !cmdHeld;
  assign pslverr = pready && !mapped;

  assign inCanvas = (regX < CANVAS_DIM) && (regY < CANVAS_DIM);
  assign paintGo = pready && cmdWrite && (pwdata == CMD_PAINT) && inCanvas;
  assign clearGo = pready && cmdWrite && (pwdata == CMD_CLEAR);

  // read mux where cmd reads back 0
  always_comb begin
    mapped = 1'b1;
    prdata = '0;
    case (paddr)
      `REG_X: prdata[7:0] = regX;
      `REG_Y: prdata[7:0] = regY;
      `REG_COLOR: prdata[2:0] = regColor;
      `REG_CMD: prdata = '0;
      `REG_STATUS: prdata[0] = busy;
      default: mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      regX <= '0;
      regY <= '0;
      regColor <= paintPkg::ERASE;
    end else if (pready && pwrite) begin
      case (paddr)
        `REG_X: regX <= pwdata[7:0];
        `REG_Y: regY <= pwdata[7:0];
        `REG_COLOR: regColor <= pwdata[2:0];
        default: ;
      endcase
    end
  end

  // clear walks every address once at one per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= paintPkg::IDLE;
      clearAddr <= '0;
    end else begin
      case (state)
        paintPkg::IDLE: begin
          if (clearGo) begin
            state <= paintPkg::CLEARING;
            clearAddr <= '0;
          end
        end
        paintPkg::CLEARING: begin
          clearAddr <= clearAddr + 1'b1;
          if (&clearAddr) begin
            state <= paintPkg::IDLE;
          end
        end
        default: state <= paintPkg::IDLE;
      endcase
    end
  end

  // store write lands one cycle after its source
  always_ff @(posedge clk) begin
    if (reset) begin
      writeEn <= 1'b0;
    end else begin
      writeEn <= busy || paintGo;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      writeAddr <= clearAddr;
      writeColor <= paintPkg::ERASE;
    end else begin
      // row then column
      writeAddr <= {regY[`CANVAS_BITS-1:0], regX[`CANVAS_BITS-1:0]};
      writeColor <= regColor;
    end
  end

  assign write = '{enable: writeEn, addr: writeAddr, color: writeColor};

  apbEnable: assert property (@(posedge clk) disable iff (reset)
    penable |-> psel)
    else $error("penable without psel");

  // while a command waits the clear keeps stepping and nothing else reaches the store
  heldNoPaint: assert property (@(posedge clk) disable iff (reset)
    cmdHeld && $past(cmdHeld) |->
      write.enable && (write.addr == $past(write.addr) + 1'b1))
    else $error("store write from held command");

endmodule

//--- pixelStore/pixelStore.sv
`include "paint_cfg.svh"

module pixelStore (
  input  logic clk,
  input  logic reset,
  input  paintPkg::rasterInfo_t raster,
  input  paintPkg::storeWrite_t write,
  output paintPkg::pixelInfo_t pixel
);

  localparam int CANVAS_DIM = 1 << `CANVAS_BITS;
  localparam int CANVAS_WORDS = CANVAS_DIM * CANVAS_DIM;

  // one read, one write, no init contents
  paintPkg::colorCode_t canvas [CANVAS_WORDS];

  paintPkg::canvasCoord_t readRow;
  paintPkg::canvasCoord_t readCol;
  paintPkg::canvasAddr_t readAddr;
  paintPkg::colorCode_t readData;
  logic outside;
  logic activeQ;
  logic hsyncQ;
  logic vsyncQ;

  // low bits only, the border flag covers the rest
  assign readRow = raster.y[`CANVAS_BITS-1:0];
  assign readCol = raster.x[`CANVAS_BITS-1:0];
  assign readAddr = {readRow, readCol};

  always_ff @(posedge clk) begin
    if (write.enable) begin
      canvas[write.addr] <= write.color;
    end
  end

  // same-address write lands after this read, so old data comes out
  always_ff @(posedge clk) begin
    readData <= canvas[readAddr];
  end

  // beyond the canvas on either axis
  always_ff @(posedge clk) begin
    if (reset) begin
      outside <= 1'b0;
      activeQ <= 1'b0;
      hsyncQ <= 1'b1;
      vsyncQ <= 1'b1;
    end else begin
      outside <= (raster.x >= CANVAS_DIM) || (raster.y >= CANVAS_DIM);
      activeQ <= raster.active;
      hsyncQ <= raster.hsync;
      vsyncQ <= raster.vsync;
    end
  end

  always_comb begin
    pixel.color = outside ? `BORDER_COLOR : readData;
    pixel.active = activeQ;
    pixel.hsync = hsyncQ;
    pixel.vsync = vsyncQ;
  end

  // write enable from the brush side must be resolved
  writeKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(write.enable))
    else $error("store write enable unknown");

endmodule

//--- logic/rasterTiming.sv
`include "paint_cfg.svh"

module rasterTiming (
  input  logic clk,
  input  logic reset,
  output paintPkg::rasterInfo_t raster
);

  // sync pulse windows
  localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
  localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;

  paintPkg::coord_t hCount;
  paintPkg::coord_t vCount;
  logic hLast;
  logic vLast;
  logic activeNext;
  logic hsyncNext;
  logic vsyncNext;

  assign hLast = hCount == paintPkg::coord_t'(`H_TOTAL - 1);
  assign vLast = vCount == paintPkg::coord_t'(`V_TOTAL - 1);

  // pixel counter, line counter steps on pixel wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      hCount <= '0;
      vCount <= '0;
    end else if (hLast) begin
      hCount <= '0;
      if (vLast) begin
        vCount <= '0;
      end else begin
        vCount <= vCount + 1'b1;
      end
    end else begin
      hCount <= hCount + 1'b1;
    end
  end

  always_comb begin
    activeNext = (hCount < `H_ACTIVE) && (vCount < `V_ACTIVE);
    // both syncs low-active
    hsyncNext = !((hCount >= H_SYNC_START) && (hCount < H_SYNC_END));
    vsyncNext = !((vCount >= V_SYNC_START) && (vCount < V_SYNC_END));
  end

  // info for count n shows up one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      raster.x <= '0;
      raster.y <= '0;
      raster.active <= 1'b0;
      raster.hsync <= 1'b1;
      raster.vsync <= 1'b1;
    end else begin
      raster.x <= hCount;
      raster.y <= vCount;
      raster.active <= activeNext;
      raster.hsync <= hsyncNext;
      raster.vsync <= vsyncNext;
    end
  end

  // counters must wrap before the totals
  counterRange: assert property (@(posedge clk) disable iff (reset)
    (hCount < `H_TOTAL) && (vCount < `V_TOTAL))
    else $error("raster counter out of range");

endmodule

//--- common/paintPkg.sv
`include "paint_cfg.svh"

package paintPkg;

  // palette index
  typedef logic [2:0] colorCode_t;

  localparam colorCode_t ERASE = 3'd0;
  localparam colorCode_t RED = 3'd1;
  localparam colorCode_t GREEN = 3'd2;
  localparam colorCode_t BLUE = 3'd3;
  localparam colorCode_t YELLOW = 3'd4;
  localparam colorCode_t PURPLE = 3'd5;
  localparam colorCode_t CYAN = 3'd6;
  localparam colorCode_t WHITE = 3'd7;

  // screen pixel or line number
  typedef logic [9:0] coord_t;

  // one canvas axis, and the row-then-column address
  typedef logic [`CANVAS_BITS-1:0] canvasCoord_t;
  typedef logic [2*`CANVAS_BITS-1:0] canvasAddr_t;

  // 4 bits each, red in the top nibble
  typedef logic [11:0] rgb_t;

  typedef enum logic {
    IDLE,
    CLEARING
  } fsmState_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    logic active;
    logic hsync;
    logic vsync;
  } rasterInfo_t;

  typedef struct packed {
    logic enable;
    canvasAddr_t addr;
    colorCode_t color;
  } storeWrite_t;

  typedef struct packed {
    colorCode_t color;
    logic active;
    logic hsync;
    logic vsync;
  } pixelInfo_t;

  typedef struct packed {
    rgb_t rgb;
    logic hsync;
    logic vsync;
  } videoOut_t;

endpackage

//--- common/paint_cfg.svh
`ifndef PAINT_CFG_SVH
`define PAINT_CFG_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical raster, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// canvas is 2**CANVAS_BITS pixels square
`define CANVAS_BITS 7

// shown outside the canvas
`define BORDER_COLOR paintPkg::BLUE

// apb register offsets
`define REG_X 8'h00
`define REG_Y 8'h04
`define REG_COLOR 8'h08
`define REG_CMD 8'h0C
`define REG_STATUS 8'h10

`endif
